// File: hdl/cheri_lu_pkg.sv
// Shared definitions for the CHERI capability logic unit
//   Register widths, object type limits and permission bit positions
//   Capability and integer views of one register word
//   Operation and exception cause encodings
//   Violation vector layout
//   Sealing and bounds helpers

package cheri_lu_pkg;

    // ------------------------------------------------
    // Widths and field constants
    // ------------------------------------------------
    localparam int unsigned XLEN    = 32;
    localparam int unsigned PERM_W  = 8;
    localparam int unsigned OTYPE_W = 4;

    // tag + perms + otype + base + length + addr
    localparam int unsigned CAP_W  = 1 + PERM_W + OTYPE_W + 3 * XLEN;
    localparam int unsigned META_W = CAP_W - XLEN;

    localparam logic [OTYPE_W-1:0] OTYPE_UNSEALED = 4'd15;
    // Types 12 to 15 are reserved
    localparam logic [OTYPE_W-1:0] OTYPE_MAX_SEAL = 4'd11;

    // Permission bit positions
    localparam int unsigned PERM_GLOBAL    = 0;
    localparam int unsigned PERM_EXECUTE   = 1;
    localparam int unsigned PERM_LOAD      = 2;
    localparam int unsigned PERM_STORE     = 3;
    localparam int unsigned PERM_LOAD_CAP  = 4;
    localparam int unsigned PERM_STORE_CAP = 5;
    localparam int unsigned PERM_SEAL      = 6;
    localparam int unsigned PERM_UNSEAL    = 7;

    // Violation vector positions
    localparam int unsigned VIOL_TAG         = 0;
    localparam int unsigned VIOL_SEAL        = 1;
    localparam int unsigned VIOL_TYPE        = 2;
    localparam int unsigned VIOL_PERM_SEAL   = 3;
    localparam int unsigned VIOL_PERM_UNSEAL = 4;
    localparam int unsigned VIOL_LENGTH      = 5;
    localparam int unsigned VIOL_NUM         = 6;

    typedef logic [VIOL_NUM-1:0] viol_vec_t;

    // ------------------------------------------------
    // Register word formats
    // ------------------------------------------------
    typedef struct packed {
        logic               tag;
        logic [PERM_W-1:0]  perms;
        logic [OTYPE_W-1:0] otype;
        logic [XLEN-1:0]    base;
        logic [XLEN-1:0]    length;
        logic [XLEN-1:0]    addr;
    } cap_t;

    // Value overlays the capability address
    typedef struct packed {
        logic [META_W-1:0] meta;
        logic [XLEN-1:0]   value;
    } int_reg_t;

    typedef union packed {
        cap_t     cap;
        int_reg_t ireg;
    } cap_word_u;

    // ------------------------------------------------
    // Encodings
    // ------------------------------------------------
    typedef enum logic [4:0] {
        CGET_ADDR    = 5'd0,
        CGET_BASE    = 5'd1,
        CGET_LEN     = 5'd2,
        CGET_TAG     = 5'd3,
        CGET_PERM    = 5'd4,
        CGET_TYPE    = 5'd5,
        CGET_SEALED  = 5'd6,
        CSET_ADDR    = 5'd7,
        CINC_OFFSET  = 5'd8,
        CAND_PERM    = 5'd9,
        CCLEAR_TAG   = 5'd10,
        CMOVE        = 5'd11,
        CSEAL        = 5'd12,
        CUNSEAL      = 5'd13,
        CSET_BOUNDS  = 5'd14,
        CSUB         = 5'd15,
        CTEST_SUBSET = 5'd16
    } cheri_op_e;

    typedef enum logic [4:0] {
        CAUSE_NONE        = 5'h00,
        CAUSE_LENGTH      = 5'h01,
        CAUSE_TAG         = 5'h02,
        CAUSE_SEAL        = 5'h03,
        CAUSE_TYPE        = 5'h04,
        CAUSE_PERM_SEAL   = 5'h17,
        CAUSE_PERM_UNSEAL = 5'h19
    } cap_cause_e;

    // ------------------------------------------------
    // Helpers
    // ------------------------------------------------
    function automatic logic cap_is_sealed(cap_t c);
        return c.otype != OTYPE_UNSEALED;
    endfunction

    // One extra bit so a region ending at 2^32 stays exact
    function automatic logic [XLEN:0] cap_top(cap_t c);
        return {1'b0, c.base} + {1'b0, c.length};
    endfunction

endpackage

// File: hdl/cheri_result_path.sv
// Result datapath of the CHERI logic unit
//   Field getters returning integer words
//   Capability modifiers, sealing and bounds setting
//   Address difference and subset test
// Purely combinational, violations are handled elsewhere

`timescale 1ns/1ps

module cheri_result_path import cheri_lu_pkg::*; (
    input  cheri_op_e op_i,
    input  cap_word_u operand_a_i,
    input  cap_word_u operand_b_i,
    output cap_word_u raw_result_o
);

    cap_t            a_cap;
    cap_t            b_cap;
    logic [XLEN-1:0] b_val;
    logic [XLEN:0]   a_top;
    logic [XLEN:0]   b_top;
    logic            b_in_a;
    logic            int_op;
    cap_word_u       result;

    // ------------------------------------------------
    // Operand decode
    // ------------------------------------------------
    assign a_cap = operand_a_i.cap;
    assign b_cap = operand_b_i.cap;
    // b read as a plain integer
    assign b_val = operand_b_i.ireg.value;

    assign a_top = cap_top(a_cap);
    assign b_top = cap_top(b_cap);

    // b lies inside a in bounds and rights
    assign b_in_a = (a_cap.tag == b_cap.tag)
                 && (b_cap.base >= a_cap.base)
                 && (b_top <= a_top)
                 && ((b_cap.perms & ~a_cap.perms) == '0);

    assign int_op = op_i inside {CGET_ADDR, CGET_BASE, CGET_LEN, CGET_TAG,
                                 CGET_PERM, CGET_TYPE, CGET_SEALED, CSUB,
                                 CTEST_SUBSET};

    // ------------------------------------------------
    // Operation select
    // ------------------------------------------------
    always_comb begin
        // Integer results start from an all zero word
        result = '0;

        unique case (op_i)
            CGET_ADDR: begin
                result.ireg.value = a_cap.addr;
            end
            CGET_BASE: begin
                result.ireg.value = a_cap.base;
            end
            CGET_LEN: begin
                result.ireg.value = a_cap.length;
            end
            CGET_TAG: begin
                result.ireg.value = XLEN'(a_cap.tag);
            end
            CGET_PERM: begin
                result.ireg.value = XLEN'(a_cap.perms);
            end
            CGET_TYPE: begin
                // Unsealed reads back as -1
                if (cap_is_sealed(a_cap)) begin
                    result.ireg.value = XLEN'(a_cap.otype);
                end else begin
                    result.ireg.value = '1;
                end
            end
            CGET_SEALED: begin
                result.ireg.value = XLEN'(cap_is_sealed(a_cap));
            end
            CSET_ADDR: begin
                result.cap      = a_cap;
                result.cap.addr = b_val;
            end
            CINC_OFFSET: begin
                result.cap      = a_cap;
                result.cap.addr = a_cap.addr + b_val;
            end
            CAND_PERM: begin
                result.cap       = a_cap;
                result.cap.perms = a_cap.perms & b_val[PERM_W-1:0];
            end
            CCLEAR_TAG: begin
                result.cap     = a_cap;
                result.cap.tag = 1'b0;
            end
            CMOVE: begin
                result.cap = a_cap;
            end
            CSEAL: begin
                result.cap       = a_cap;
                result.cap.otype = b_cap.addr[OTYPE_W-1:0];
            end
            CUNSEAL: begin
                result.cap       = a_cap;
                result.cap.otype = OTYPE_UNSEALED;
                // Global only survives if the authority is global too
                result.cap.perms[PERM_GLOBAL] = a_cap.perms[PERM_GLOBAL]
                                              & b_cap.perms[PERM_GLOBAL];
            end
            CSET_BOUNDS: begin
                // Format is uncompressed so the request is always exact
                result.cap        = a_cap;
                result.cap.base   = a_cap.addr;
                result.cap.length = b_val;
            end
            CSUB: begin
                result.ireg.value = a_cap.addr - b_cap.addr;
            end
            CTEST_SUBSET: begin
                result.ireg.value = XLEN'(b_in_a);
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign raw_result_o = result;

    // Integer results must read as untagged words with no metadata
    always_comb begin
        if (int_op) begin
            assert final (raw_result_o.ireg.meta == '0)
                else $error("integer op %s returned nonzero meta", op_i.name());
        end
    end

endmodule

// File: hdl/cheri_violation_check.sv
// Operand violation checker of the CHERI logic unit
//   Raw tag, seal, type, permission and length violations per operand
//   Check set of each operation
//   Trap enable for the sealing and bounds operations

`timescale 1ns/1ps

module cheri_violation_check import cheri_lu_pkg::*; (
    input  cheri_op_e op_i,
    input  cap_word_u operand_a_i,
    input  cap_word_u operand_b_i,
    output viol_vec_t viol_a_o,
    output viol_vec_t viol_b_o,
    output logic      trap_en_o
);

    cap_t            a_cap;
    cap_t            b_cap;
    logic [XLEN-1:0] b_val;
    logic [XLEN:0]   a_top;
    logic [XLEN:0]   b_top;
    logic [XLEN:0]   req_top;
    viol_vec_t       raw_a;
    viol_vec_t       raw_b;
    viol_vec_t       chk_a;
    viol_vec_t       chk_b;

    assign a_cap = operand_a_i.cap;
    assign b_cap = operand_b_i.cap;
    assign b_val = operand_b_i.ireg.value;

    assign a_top = cap_top(a_cap);
    assign b_top = cap_top(b_cap);

    // End of the region CSetBounds asks for
    assign req_top = {1'b0, a_cap.addr} + {1'b0, b_val};

    // ------------------------------------------------
    // Raw violations
    // ------------------------------------------------
    always_comb begin
        raw_a = '0;
        raw_b = '0;

        raw_a[VIOL_TAG] = !a_cap.tag;
        // Unsealing inverts the sense of the seal check
        if (op_i == CUNSEAL) begin
            raw_a[VIOL_SEAL] = !cap_is_sealed(a_cap);
        end else begin
            raw_a[VIOL_SEAL] = cap_is_sealed(a_cap);
        end
        raw_a[VIOL_LENGTH] = (a_cap.addr < a_cap.base) || (req_top > a_top);

        raw_b[VIOL_TAG]         = !b_cap.tag;
        raw_b[VIOL_SEAL]        = cap_is_sealed(b_cap);
        raw_b[VIOL_PERM_SEAL]   = !b_cap.perms[PERM_SEAL];
        raw_b[VIOL_PERM_UNSEAL] = !b_cap.perms[PERM_UNSEAL];

        // Authority address is the object type
        if (op_i == CUNSEAL) begin
            raw_b[VIOL_TYPE] = b_cap.addr != XLEN'(a_cap.otype);
        end else begin
            raw_b[VIOL_TYPE] = b_cap.addr > XLEN'(OTYPE_MAX_SEAL);
        end

        // and it has to sit inside the authority's own bounds
        raw_b[VIOL_LENGTH] = (b_cap.addr < b_cap.base) || ({1'b0, b_cap.addr} >= b_top);
    end

    // ------------------------------------------------
    // Check set per operation
    // ------------------------------------------------
    always_comb begin
        chk_a = '0;
        chk_b = '0;

        unique case (op_i)
            CSET_ADDR, CINC_OFFSET, CAND_PERM: begin
                chk_a[VIOL_SEAL] = 1'b1;
            end
            CSEAL: begin
                chk_a[VIOL_TAG]       = 1'b1;
                chk_a[VIOL_SEAL]      = 1'b1;
                chk_b[VIOL_TAG]       = 1'b1;
                chk_b[VIOL_SEAL]      = 1'b1;
                chk_b[VIOL_PERM_SEAL] = 1'b1;
                chk_b[VIOL_TYPE]      = 1'b1;
                chk_b[VIOL_LENGTH]    = 1'b1;
            end
            CUNSEAL: begin
                chk_a[VIOL_TAG]         = 1'b1;
                chk_a[VIOL_SEAL]        = 1'b1;
                chk_b[VIOL_TAG]         = 1'b1;
                chk_b[VIOL_SEAL]        = 1'b1;
                chk_b[VIOL_PERM_UNSEAL] = 1'b1;
                chk_b[VIOL_TYPE]        = 1'b1;
                chk_b[VIOL_LENGTH]      = 1'b1;
            end
            CSET_BOUNDS: begin
                chk_a[VIOL_TAG]    = 1'b1;
                chk_a[VIOL_SEAL]   = 1'b1;
                chk_a[VIOL_LENGTH] = 1'b1;
            end
            default: begin
                chk_a = '0;
                chk_b = '0;
            end
        endcase
    end

    assign viol_a_o = raw_a & chk_a;
    assign viol_b_o = raw_b & chk_b;

    // Only these raise an exception, the rest just lose the tag
    assign trap_en_o = op_i inside {CSEAL, CUNSEAL, CSET_BOUNDS};

    // Getters never trap
    always_comb begin
        if (op_i inside {CGET_ADDR, CGET_BASE, CGET_LEN, CGET_TAG,
                         CGET_PERM, CGET_TYPE, CGET_SEALED}) begin
            assert final (!trap_en_o)
                else $error("trap enabled for getter %s", op_i.name());
        end
    end

endmodule

// File: hdl/cheri_result_merge.sv
// Result merge stage of the CHERI logic unit
//   Tag clearing on any checked violation
//   Exception cause selection by fixed priority
//   Output registers, the only state in the unit

`timescale 1ns/1ps

module cheri_result_merge import cheri_lu_pkg::*; (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       valid_i,
    input  cap_word_u  raw_result_i,
    input  viol_vec_t  viol_a_i,
    input  viol_vec_t  viol_b_i,
    input  logic       trap_en_i,
    output logic       result_valid_o,
    output cap_word_u  result_o,
    output logic       ex_valid_o,
    output cap_cause_e ex_cause_o
);

    viol_vec_t  viol_all;
    logic       any_viol;
    logic       ex_valid_d;
    cap_cause_e cause_d;
    cap_word_u  result_d;

    // a and b map to the same cause, so one vector is enough
    assign viol_all = viol_a_i | viol_b_i;
    assign any_viol = |viol_all;

    always_comb begin
        result_d = raw_result_i;
        if (any_viol) begin
            result_d.cap.tag = 1'b0;
        end
    end

    // ------------------------------------------------
    // Cause priority
    // ------------------------------------------------
    always_comb begin
        if (viol_all[VIOL_TAG]) begin
            cause_d = CAUSE_TAG;
        end else if (viol_all[VIOL_SEAL]) begin
            cause_d = CAUSE_SEAL;
        end else if (viol_all[VIOL_TYPE]) begin
            cause_d = CAUSE_TYPE;
        end else if (viol_all[VIOL_PERM_SEAL]) begin
            cause_d = CAUSE_PERM_SEAL;
        end else if (viol_all[VIOL_PERM_UNSEAL]) begin
            cause_d = CAUSE_PERM_UNSEAL;
        end else if (viol_all[VIOL_LENGTH]) begin
            cause_d = CAUSE_LENGTH;
        end else begin
            cause_d = CAUSE_NONE;
        end
    end

    assign ex_valid_d = valid_i && trap_en_i && any_viol;

    // ------------------------------------------------
    // Output registers
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_valid_o <= 1'b0;
            ex_valid_o     <= 1'b0;
            ex_cause_o     <= CAUSE_NONE;
        end else begin
            result_valid_o <= valid_i;
            ex_valid_o     <= ex_valid_d;
            ex_cause_o     <= ex_valid_d ? cause_d : CAUSE_NONE;
        end
    end

    // Payload only moves with a new operation
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            result_o <= result_d;
        end
    end

    // An exception always rides on a returned result
    ex_has_result: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ex_valid_o |-> result_valid_o)
        else $error("exception without a result");

    ex_has_cause: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ex_valid_o |-> (ex_cause_o != CAUSE_NONE))
        else $error("exception raised with no cause");

endmodule

// File: hdl/cheri_lu_top.sv
// Top level of the CHERI capability logic unit
//   Result datapath and violation checker side by side
//   Merge stage registers result and exception

`timescale 1ns/1ps

module cheri_lu_top import cheri_lu_pkg::*; (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       valid_i,
    input  cheri_op_e  op_i,
    input  cap_word_u  operand_a_i,
    input  cap_word_u  operand_b_i,
    output logic       result_valid_o,
    output cap_word_u  result_o,
    output logic       ex_valid_o,
    output cap_cause_e ex_cause_o
);

    cap_word_u raw_result;
    viol_vec_t viol_a;
    viol_vec_t viol_b;
    logic      trap_en;

    cheri_result_path u_result_path (
        .op_i         (op_i),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .raw_result_o (raw_result)
    );

    cheri_violation_check u_violation_check (
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .viol_a_o    (viol_a),
        .viol_b_o    (viol_b),
        .trap_en_o   (trap_en)
    );

    // Single register stage, one result per cycle
    cheri_result_merge u_result_merge (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .valid_i        (valid_i),
        .raw_result_i   (raw_result),
        .viol_a_i       (viol_a),
        .viol_b_i       (viol_b),
        .trap_en_i      (trap_en),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .ex_valid_o     (ex_valid_o),
        .ex_cause_o     (ex_cause_o)
    );

endmodule

// File: include/cheri_lu_tb_tasks.svh
// Testbench helpers for the CHERI logic unit
//   Typed compare tasks for result words, exception causes and flags
//   Operation drive with a bounded wait for the result

`ifndef CHERI_LU_TB_TASKS_SVH
`define CHERI_LU_TB_TASKS_SVH

task automatic compare_word(input cap_word_u got, input cap_word_u exp, input string what);
    if (got !== exp) begin
        $display("[ERROR] %0t ns: %s result %h, expected %h", $time, what, got, exp);
        error_count++;
    end
endtask

task automatic compare_cause(input logic got_valid, input cap_cause_e got_cause,
                             input logic exp_valid, input cap_cause_e exp_cause,
                             input string what);
    if (got_valid !== exp_valid || got_cause !== exp_cause) begin
        $display("[ERROR] %0t ns: %s exception %b cause %h, expected %b cause %h",
                 $time, what, got_valid, got_cause, exp_valid, exp_cause);
        error_count++;
    end
endtask

task automatic compare_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
        error_count++;
    end
endtask

// One operation in, then wait for its result
task automatic run_op(input cheri_op_e op, input cap_word_u a, input cap_word_u b,
                      input cap_word_u exp, input logic exp_ex,
                      input cap_cause_e exp_cause, input string what);
    int cycles;
    @(negedge clk);
    valid     = 1'b1;
    op_drv    = op;
    operand_a = a;
    operand_b = b;
    @(negedge clk);
    valid     = 1'b0;
    operand_a = '0;
    operand_b = '0;
    cycles    = 1;
    while (!res_valid && cycles < WAIT_LIMIT) begin
        @(negedge clk);
        cycles++;
    end
    if (!res_valid) begin
        $display("Timeout: no result arrived for %s within %0d cycles", what, WAIT_LIMIT);
        timeout_count++;
    end else begin
        if (cycles != 1) begin
            $display("[ERROR] %0t ns: %s result after %0d cycles, expected 1",
                     $time, what, cycles);
            error_count++;
        end
        compare_word(res_word, exp, what);
        compare_cause(ex_valid, ex_cause, exp_ex, exp_cause, what);
    end
endtask

task automatic run_no_trap(input cheri_op_e op, input cap_word_u a, input cap_word_u b,
                           input cap_word_u exp, input string what);
    run_op(op, a, b, exp, 1'b0, CAUSE_NONE, what);
endtask

`endif

// File: verification/cheri_lu_tb.sv
// Directed testbench for the CHERI capability logic unit
//   Clock, reset and DUT instance
//   Tests for latency, getters, modifiers, sealing, unsealing and bounds
//   Error counts and final verdict

`timescale 1ns/1ps

module cheri_lu_tb import cheri_lu_pkg::*; ();

    localparam int WAIT_LIMIT = 16;

    logic       clk;
    logic       arst_n;
    logic       valid;
    cheri_op_e  op_drv;
    cap_word_u  operand_a;
    cap_word_u  operand_b;
    logic       res_valid;
    cap_word_u  res_word;
    logic       ex_valid;
    cap_cause_e ex_cause;
    int         error_count;
    int         timeout_count;

    `include "cheri_lu_tb_tasks.svh"

    cheri_lu_top dut (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .valid_i        (valid),
        .op_i           (op_drv),
        .operand_a_i    (operand_a),
        .operand_b_i    (operand_b),
        .result_valid_o (res_valid),
        .result_o       (res_word),
        .ex_valid_o     (ex_valid),
        .ex_cause_o     (ex_cause)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // --------------------------------------------------
    // Stimulus builders
    // --------------------------------------------------
    function automatic cap_word_u make_cap(input logic tag, input logic [PERM_W-1:0] perms,
                                           input logic [OTYPE_W-1:0] otype,
                                           input logic [XLEN-1:0] base,
                                           input logic [XLEN-1:0] length,
                                           input logic [XLEN-1:0] addr);
        cap_word_u w;
        w.cap.tag    = tag;
        w.cap.perms  = perms;
        w.cap.otype  = otype;
        w.cap.base   = base;
        w.cap.length = length;
        w.cap.addr   = addr;
        return w;
    endfunction

    function automatic cap_word_u int_word(input logic [XLEN-1:0] value);
        cap_word_u w;
        w            = '0;
        w.ireg.value = value;
        return w;
    endfunction

    // Tagged and unsealed, addr inside bounds, unseal right left clear
    function automatic cap_word_u rand_cap();
        logic [XLEN-1:0]   base;
        logic [XLEN-1:0]   length;
        logic [PERM_W-1:0] perms;
        base   = $urandom & 32'h00ff_fff0;
        length = ($urandom & 32'h0000_ffff) + 32'd16;
        perms  = PERM_W'($urandom) & 8'h7f;
        return make_cap(1'b1, perms, 4'd15, base, length, base + ($urandom % length));
    endfunction

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_reset_latency();
        cap_word_u a [3];
        int        i;
        compare_bit(res_valid, 1'b0, "result_valid_o after reset");
        compare_cause(ex_valid, ex_cause, 1'b0, CAUSE_NONE, "after reset");
        a[0] = rand_cap();
        run_no_trap(CGET_ADDR, a[0], int_word('0), int_word(a[0].cap.addr), "single op");
        for (i = 0; i < 3; i++) begin
            a[i] = rand_cap();
        end
        // One result per cycle while the next op goes in
        for (i = 0; i <= 3; i++) begin
            @(negedge clk);
            if (i > 0) begin
                compare_bit(res_valid, 1'b1, "back-to-back result_valid_o");
                compare_word(res_word, int_word(a[i-1].cap.addr), "back-to-back CGetAddr");
            end
            valid = (i < 3);
            if (i < 3) begin
                op_drv    = CGET_ADDR;
                operand_a = a[i];
            end
        end
        @(negedge clk);
        compare_bit(res_valid, 1'b0, "result_valid_o after burst");
    endtask

    task automatic test_getters();
        cap_word_u a;
        cap_word_u b;
        cap_word_u z;
        a = rand_cap();
        b = rand_cap();
        z = int_word('0);
        run_no_trap(CGET_ADDR, a, z, int_word(a.cap.addr), "CGetAddr");
        run_no_trap(CGET_BASE, a, z, int_word(a.cap.base), "CGetBase");
        run_no_trap(CGET_LEN, a, z, int_word(a.cap.length), "CGetLen");
        run_no_trap(CGET_TAG, a, z, int_word(32'd1), "CGetTag");
        run_no_trap(CGET_PERM, a, z, int_word(XLEN'(a.cap.perms)), "CGetPerm");
        run_no_trap(CGET_TYPE, a, z, int_word(32'hffff_ffff), "CGetType unsealed");
        run_no_trap(CGET_SEALED, a, z, int_word(32'd0), "CGetSealed");
        run_no_trap(CSUB, a, b, int_word(a.cap.addr - b.cap.addr), "CSub");
        // Narrowed copy with fewer rights
        b             = a;
        b.cap.base    = a.cap.base + 32'd4;
        b.cap.length  = a.cap.length - 32'd8;
        b.cap.perms   = a.cap.perms & 8'h0f;
        run_no_trap(CTEST_SUBSET, a, b, int_word(32'd1), "CTestSubset narrowed");
        b.cap.perms[PERM_UNSEAL] = 1'b1;
        run_no_trap(CTEST_SUBSET, a, b, int_word(32'd0), "CTestSubset extra perm");
    endtask

    task automatic test_modifiers();
        cap_word_u       a;
        cap_word_u       b;
        cap_word_u       exp;
        logic [XLEN-1:0] v;
        a = rand_cap();
        v = $urandom;
        b = int_word(v);
        exp = a;
        exp.cap.addr = v;
        run_no_trap(CSET_ADDR, a, b, exp, "CSetAddr");
        exp = a;
        exp.cap.addr = a.cap.addr + v;
        run_no_trap(CINC_OFFSET, a, b, exp, "CIncOffset");
        exp = a;
        exp.cap.perms = a.cap.perms & v[PERM_W-1:0];
        run_no_trap(CAND_PERM, a, b, exp, "CAndPerm");
        exp = a;
        exp.cap.tag = 1'b0;
        run_no_trap(CCLEAR_TAG, a, b, exp, "CClearTag");
        run_no_trap(CMOVE, a, b, a, "CMove");
        // Sealed a keeps the result and loses the tag without a trap
        a.cap.otype = 4'd3;
        exp = a;
        exp.cap.tag  = 1'b0;
        exp.cap.addr = v;
        run_no_trap(CSET_ADDR, a, b, exp, "CSetAddr sealed");
        exp.cap.addr = a.cap.addr + v;
        run_no_trap(CINC_OFFSET, a, b, exp, "CIncOffset sealed");
        exp.cap.addr  = a.cap.addr;
        exp.cap.perms = a.cap.perms & v[PERM_W-1:0];
        run_no_trap(CAND_PERM, a, b, exp, "CAndPerm sealed");
    endtask

    task automatic test_sealing();
        cap_word_u a;
        cap_word_u auth;
        cap_word_u exp;
        a    = rand_cap();
        auth = make_cap(1'b1, 8'h41, 4'd15, 32'd0, 32'd16, 32'd5);
        exp  = a;
        exp.cap.otype = 4'd5;
        run_no_trap(CSEAL, a, auth, exp, "CSeal");
        auth.cap.perms[PERM_SEAL] = 1'b0;
        exp.cap.tag = 1'b0;
        run_op(CSEAL, a, auth, exp, 1'b1, CAUSE_PERM_SEAL, "CSeal without seal perm");
        // Tag fault outranks the missing permission
        a.cap.tag = 1'b0;
        run_op(CSEAL, a, auth, exp, 1'b1, CAUSE_TAG, "CSeal untagged");
        a.cap.tag = 1'b1;
        auth.cap.perms[PERM_SEAL] = 1'b1;
        auth.cap.addr = 32'd13;
        exp.cap.otype = 4'd13;
        run_op(CSEAL, a, auth, exp, 1'b1, CAUSE_TYPE, "CSeal reserved otype");
    endtask

    task automatic test_unsealing();
        cap_word_u a;
        cap_word_u auth;
        cap_word_u exp;
        a = rand_cap();
        a.cap.perms[PERM_GLOBAL] = 1'b1;
        a.cap.otype = 4'd5;
        // Authority is not global
        auth = make_cap(1'b1, 8'h80, 4'd15, 32'd0, 32'd16, 32'd5);
        exp  = a;
        exp.cap.otype = 4'd15;
        exp.cap.perms[PERM_GLOBAL] = 1'b0;
        run_no_trap(CUNSEAL, a, auth, exp, "CUnseal");
        auth.cap.addr = 32'd6;
        exp.cap.tag = 1'b0;
        run_op(CUNSEAL, a, auth, exp, 1'b1, CAUSE_TYPE, "CUnseal wrong otype");
        a.cap.otype = 4'd15;
        auth.cap.addr = 32'd5;
        run_op(CUNSEAL, a, auth, exp, 1'b1, CAUSE_SEAL, "CUnseal of unsealed");
    endtask

    task automatic test_bounds();
        cap_word_u       a;
        cap_word_u       exp;
        logic [XLEN-1:0] base;
        base = $urandom & 32'h0fff_f000;
        a    = make_cap(1'b1, 8'h3f, 4'd15, base, 32'h100, base + 32'h40);
        exp  = a;
        exp.cap.base   = base + 32'h40;
        exp.cap.length = 32'h40;
        run_no_trap(CSET_BOUNDS, a, int_word(32'h40), exp, "CSetBounds inside");
        // Ends 0x40 past the top of a
        exp.cap.length = 32'h100;
        exp.cap.tag    = 1'b0;
        run_op(CSET_BOUNDS, a, int_word(32'h100), exp, 1'b1, CAUSE_LENGTH,
               "CSetBounds past top");
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        void'($urandom(32'h48f8_e365));
        error_count   = 0;
        timeout_count = 0;
        arst_n    = 1'b0;
        valid     = 1'b0;
        op_drv    = CGET_ADDR;
        operand_a = '0;
        operand_b = '0;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;

        test_reset_latency();
        test_getters();
        test_modifiers();
        test_sealing();
        test_unsealing();
        test_bounds();

        @(negedge clk);
        $display("Checks done: %0d mismatches, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
hdl/cheri_lu_pkg.sv
hdl/cheri_result_path.sv
hdl/cheri_violation_check.sv
hdl/cheri_result_merge.sv
hdl/cheri_lu_top.sv
verification/cheri_lu_tb.sv
